//--- adc_front_pkg.sv
package adc_front_pkg;

   // datapath widths
   localparam int SAMPLE_W   = 12;
   localparam int REG_W      = 8;
   localparam int ADDR_W     = 3;
   localparam int LEVEL_HI_W = SAMPLE_W - REG_W;  // level bits above the low byte

   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [REG_W-1:0]    reg_byte_t;

   // register map on the wishbone slave
   typedef enum logic [ADDR_W-1:0] {
      REG_GAIN     = 3'd0,  // pwm increment
      REG_LEVEL_LO = 3'd1,  // level 7:0
      REG_LEVEL_HI = 3'd2,  // level 11:8 in data 3:0
      REG_SETTINGS = 3'd3,  // bit0 arm, bit1 source_adc
      REG_STATUS   = 3'd4   // read only, bit0 armed, bit1 fired
   } reg_addr_e;

   // decoded bus cycle
   typedef enum logic [1:0] {
      OP_IDLE  = 2'd0,
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } bus_op_e;

   // single shot level trigger
   typedef enum logic [1:0] {
      TRIG_IDLE  = 2'd0,
      TRIG_ARMED = 2'd1,
      TRIG_FIRED = 2'd2
   } trig_state_e;

endpackage

//--- adc_ctrl_if.sv
`timescale 1ns/1ps

interface adc_ctrl_if;
   import adc_front_pkg::*;

   reg_byte_t gain;        // pwm increment
   sample_t   level;       // trigger level, bit 11 picks polarity
   logic      arm;         // settings bit 0
   logic      source_adc;  // 1 = adc input, 0 = ramp
   logic      armed;
   logic      fired;

   modport decode_mp (
      output gain, level, arm, source_adc,
      input  armed, fired
   );

   modport trigger_mp (
      input  level, arm, source_adc,
      output armed, fired
   );

   modport pwm_mp (
      input gain, armed
   );

endinterface

//--- adc_reg_decode.sv
`timescale 1ns/1ps

module adc_reg_decode (
   input  logic                             clk_usb,
   input  logic                             reset,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [adc_front_pkg::ADDR_W-1:0] wb_adr_i,
   input  adc_front_pkg::reg_byte_t         wb_dat_i,
   output adc_front_pkg::reg_byte_t         wb_dat_o,
   output logic                             wb_ack_o,
   adc_ctrl_if.decode_mp                    ctrl
);
   import adc_front_pkg::*;

   bus_op_e         bus_op;
   reg_addr_e       reg_addr;
   reg_byte_t       read_data;
   reg_byte_t       gain_q;
   sample_t         level_q;
   logic [1:0]      settings_q;  // {source_adc, arm}

   // a request is cyc and stb; only taken while ack is low
   always_comb begin
      reg_addr = reg_addr_e'(wb_adr_i);
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
         bus_op = wb_we_i ? OP_WRITE : OP_READ;
      end else begin
         bus_op = OP_IDLE;
      end
   end

   // read-back mux
   always_comb begin
      read_data = '0;
      case (reg_addr)
         REG_GAIN:     read_data = gain_q;
         REG_LEVEL_LO: read_data = level_q[REG_W-1:0];
         REG_LEVEL_HI: read_data = {{(REG_W-LEVEL_HI_W){1'b0}}, level_q[SAMPLE_W-1:REG_W]};
         REG_SETTINGS: read_data = {{(REG_W-2){1'b0}}, settings_q};
         REG_STATUS:   read_data = {{(REG_W-2){1'b0}}, ctrl.fired, ctrl.armed};
         default:      read_data = '0;  // unmapped reads zero
      endcase
   end

   // register writes land on the same edge that raises ack
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q     <= '0;
         level_q    <= '0;
         settings_q <= '0;
      end else if (bus_op == OP_WRITE) begin
         case (reg_addr)
            REG_GAIN:     gain_q <= wb_dat_i;
            REG_LEVEL_LO: level_q[REG_W-1:0] <= wb_dat_i;
            REG_LEVEL_HI: level_q[SAMPLE_W-1:REG_W] <= wb_dat_i[LEVEL_HI_W-1:0];
            REG_SETTINGS: settings_q <= wb_dat_i[1:0];
            default: ;  // status and unmapped ignore writes
         endcase
      end
   end

   // one cycle ack, never back to back
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= (bus_op != OP_IDLE);
      end
   end

   always_ff @(posedge clk_usb) begin
      if (bus_op == OP_READ) begin
         wb_dat_o <= read_data;  // valid while ack is high
      end
   end

   assign ctrl.gain       = gain_q;
   assign ctrl.level      = level_q;
   assign ctrl.arm        = settings_q[0];
   assign ctrl.source_adc = settings_q[1];

endmodule

//--- adc_level_trigger.sv
`timescale 1ns/1ps

module adc_level_trigger (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  adc_front_pkg::sample_t adc_data_i,
   input  logic                   adc_valid_i,
   output adc_front_pkg::sample_t sample_data_o,
   output logic                   sample_valid_o,
   output logic                   trigger_adc_o,
   adc_ctrl_if.trigger_mp         ctrl
);
   import adc_front_pkg::*;

   trig_state_e state_q;
   sample_t     ramp_q;      // internal test pattern
   sample_t     dly_pre;     // first resample stage
   sample_t     dly_out;     // second stage seen by consumer and trigger
   logic        arm_q;
   logic        arm_rise;
   logic        level_hit;

   // two stage resampling delay that moves only on valid strobes
   always_ff @(posedge clk_usb) begin
      if (adc_valid_i) begin
         dly_pre <= ctrl.source_adc ? adc_data_i : ramp_q;
         dly_out <= dly_pre;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ramp_q         <= '0;
         sample_valid_o <= 1'b0;
      end else begin
         sample_valid_o <= adc_valid_i;
         if (adc_valid_i) begin
            ramp_q <= ramp_q + sample_t'(1);
         end
      end
   end

   assign sample_data_o = dly_out;

   always_comb begin
      arm_rise = ctrl.arm && !arm_q;
      // level bit 11 set fires above the level and clear fires below
      if (ctrl.level[SAMPLE_W-1]) begin
         level_hit = (dly_out > ctrl.level);
      end else begin
         level_hit = (dly_out < ctrl.level);
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q       <= TRIG_IDLE;
         arm_q         <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         arm_q         <= ctrl.arm;
         trigger_adc_o <= 1'b0;  // single cycle pulse
         case (state_q)
            TRIG_ARMED: begin
               if (adc_valid_i && level_hit) begin
                  state_q       <= TRIG_FIRED;
                  trigger_adc_o <= 1'b1;
               end
            end
            default: begin
               // idle and fired both wait for the next arm edge
               if (arm_rise) begin
                  state_q <= TRIG_ARMED;
               end
            end
         endcase
      end
   end

   assign ctrl.armed = (state_q == TRIG_ARMED);
   assign ctrl.fired = (state_q == TRIG_FIRED);

endmodule

//--- adc_gain_pwm.sv
`timescale 1ns/1ps

module adc_gain_pwm (
   input  logic       clk_usb,
   input  logic       reset,
   output logic       amp_gain_o,
   output logic       led_armed_o,
   adc_ctrl_if.pwm_mp ctrl
);
   import adc_front_pkg::*;

   logic [REG_W:0] pwm_acc;  // carry sits in the top bit

   // first order accumulator, carry density = gain / 256
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_acc <= '0;
      end else begin
         pwm_acc <= {1'b0, pwm_acc[REG_W-1:0]} + {1'b0, ctrl.gain};
      end
   end

   assign amp_gain_o = pwm_acc[REG_W];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         led_armed_o <= 1'b0;
      end else begin
         led_armed_o <= ctrl.armed;  // one cycle behind status
      end
   end

endmodule

//--- adc_front_top.sv
`timescale 1ns/1ps

module adc_front_top (
   input  logic                             clk_usb,
   input  logic                             reset,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [adc_front_pkg::ADDR_W-1:0] wb_adr_i,
   input  adc_front_pkg::reg_byte_t         wb_dat_i,
   output adc_front_pkg::reg_byte_t         wb_dat_o,
   output logic                             wb_ack_o,
   input  adc_front_pkg::sample_t           adc_data_i,
   input  logic                             adc_valid_i,
   output adc_front_pkg::sample_t           sample_data_o,
   output logic                             sample_valid_o,
   output logic                             trigger_adc_o,
   output logic                             amp_gain_o,
   output logic                             led_armed_o,
   output logic                             led_capture_o
);

   adc_ctrl_if ctrl_bus ();

   adc_reg_decode u_decode (
      .clk_usb  (clk_usb),
      .reset    (reset),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .ctrl     (ctrl_bus.decode_mp)
   );

   adc_level_trigger u_trigger (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .adc_valid_i    (adc_valid_i),
      .sample_data_o  (sample_data_o),
      .sample_valid_o (sample_valid_o),
      .trigger_adc_o  (trigger_adc_o),
      .ctrl           (ctrl_bus.trigger_mp)
   );

   adc_gain_pwm u_pwm (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .amp_gain_o  (amp_gain_o),
      .led_armed_o (led_armed_o),
      .ctrl        (ctrl_bus.pwm_mp)
   );

   assign led_capture_o = ctrl_bus.fired;  // capture led shows the fired state

endmodule

//--- tb_adc_checks.svh
// compare tasks, one per result type
task automatic check_sample(input string name, input sample_t exp, input sample_t act);
   if (act !== exp) begin
      $display("Error %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
   end
endtask

task automatic check_byte(input string name, input reg_byte_t exp, input reg_byte_t act);
   if (act !== exp) begin
      $display("Error %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("Error %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
   end
endtask

task automatic check_count(input string name, input int exp, input int act);
   if (act != exp) begin
      $display("Error %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
   end
endtask

// wishbone master side
task automatic wait_ack();
   int n;
   n = 0;
   do begin
      @(posedge clk_usb);
      n++;
      if (n > 4) begin
         $display("Test failed");
         $fatal(1, "wishbone request was never acknowledged");
      end
   end while (!wb_ack_o);
endtask

task automatic bus_write(input logic [ADDR_W-1:0] adr, input reg_byte_t dat);
   @(posedge clk_usb);
   wb_cyc_i <= 1'b1;
   wb_stb_i <= 1'b1;
   wb_we_i  <= 1'b1;
   wb_adr_i <= adr;
   wb_dat_i <= dat;
   wait_ack();
   wb_cyc_i <= 1'b0;  // drop the request on the ack edge
   wb_stb_i <= 1'b0;
   wb_we_i  <= 1'b0;
endtask

task automatic bus_read(input logic [ADDR_W-1:0] adr, output reg_byte_t dat);
   @(posedge clk_usb);
   wb_cyc_i <= 1'b1;
   wb_stb_i <= 1'b1;
   wb_we_i  <= 1'b0;
   wb_adr_i <= adr;
   wait_ack();
   dat = wb_dat_o;  // still the value held during ack
   wb_cyc_i <= 1'b0;
   wb_stb_i <= 1'b0;
endtask

//--- tb_adc_front.sv
`timescale 1ns/1ps

module tb_adc_front;
   import adc_front_pkg::*;

   localparam int ROUNDS      = 20;
   localparam int CYCLE_LIMIT = ROUNDS * 300 + 2000;

   logic clk_usb = 1'b0;
   logic reset, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic [ADDR_W-1:0] wb_adr_i;
   reg_byte_t wb_dat_i, wb_dat_o;
   sample_t adc_data_i, sample_data_o;
   logic adc_valid_i, sample_valid_o, trigger_adc_o, amp_gain_o, led_armed_o, led_capture_o;

   // model state
   reg_byte_t   m_gain, m_rdata;
   sample_t     m_level, m_ramp, m_pre, m_out;
   logic        m_arm, m_src, m_arm_q, m_svalid, m_trig, m_ack, m_rd, m_led;
   trig_state_e m_state;
   logic [REG_W:0] m_acc;
   int          vcount;
   logic        model_live = 1'b0;
   int          cycle_cnt = 0;
   logic [31:0] rng_drv, rng_main;

   adc_front_top uut (.*);

   always #20 clk_usb = ~clk_usb;

   `include "tb_adc_checks.svh"

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic crosses(input sample_t s, input sample_t lvl);
      if (lvl[SAMPLE_W-1]) return s > lvl;  // above
      return s < lvl;
   endfunction

   function automatic reg_byte_t model_read(input reg_addr_e a);
      case (a)
         REG_GAIN:     return m_gain;
         REG_LEVEL_LO: return m_level[7:0];
         REG_LEVEL_HI: return {4'b0, m_level[11:8]};
         REG_SETTINGS: return {6'b0, m_src, m_arm};
         REG_STATUS:   return {6'b0, m_state == TRIG_FIRED, m_state == TRIG_ARMED};
         default:      return 8'h00;
      endcase
   endfunction

   // value a register should return after a write of d
   function automatic reg_byte_t written_value(input logic [ADDR_W-1:0] a, input reg_byte_t d);
      case (a)
         3'd0, 3'd1: return d;
         3'd2:       return {4'b0, d[3:0]};
         3'd3:       return {6'b0, d[1:0]};
         default:    return 8'h00;
      endcase
   endfunction

   always @(posedge clk_usb) begin
      rng_drv = xorshift(rng_drv);
      adc_valid_i <= rng_drv[7];  // about half the cycles
      adc_data_i  <= rng_drv[27:16];
   end

   always @(posedge clk_usb) begin
      model_live <= 1'b1;
      if (reset) begin
         {m_gain, m_level, m_arm, m_src} <= '0;
         {m_ramp, m_svalid, m_trig, m_arm_q, m_ack, m_rd, m_led, m_acc} <= '0;
         m_state <= TRIG_IDLE;
         vcount  <= 0;
      end else begin
         m_svalid <= adc_valid_i;
         if (adc_valid_i) begin
            m_pre  <= m_src ? adc_data_i : m_ramp;
            m_out  <= m_pre;
            m_ramp <= m_ramp + sample_t'(1);
            if (vcount < 2) vcount <= vcount + 1;
         end
         m_arm_q <= m_arm;
         m_trig  <= 1'b0;
         if (m_state == TRIG_ARMED) begin
            if (adc_valid_i && crosses(m_out, m_level)) begin
               m_state <= TRIG_FIRED;
               m_trig  <= 1'b1;
            end
         end else if (m_arm && !m_arm_q) begin
            m_state <= TRIG_ARMED;
         end
         m_acc <= {1'b0, m_acc[REG_W-1:0]} + {1'b0, m_gain};
         m_led <= (m_state == TRIG_ARMED);
         m_ack <= wb_cyc_i && wb_stb_i && !m_ack;
         if (wb_cyc_i && wb_stb_i && !m_ack) begin
            m_rd    <= !wb_we_i;
            m_rdata <= model_read(reg_addr_e'(wb_adr_i));
            if (wb_we_i) begin
               case (wb_adr_i)
                  3'd0: m_gain <= wb_dat_i;
                  3'd1: m_level[7:0] <= wb_dat_i;
                  3'd2: m_level[11:8] <= wb_dat_i[3:0];
                  3'd3: {m_src, m_arm} <= wb_dat_i[1:0];
                  default: ;
               endcase
            end
         end
      end
   end

   // outputs are settled by the falling edge
   always @(negedge clk_usb) begin
      if (model_live) begin
         check_bit("wb_ack_o", m_ack, wb_ack_o);
         if (m_ack && m_rd) check_byte("wb_dat_o", m_rdata, wb_dat_o);
         check_bit("sample_valid_o", m_svalid, sample_valid_o);
         if (m_svalid && vcount >= 2) check_sample("sample_data_o", m_out, sample_data_o);
         check_bit("trigger_adc_o", m_trig, trigger_adc_o);
         check_bit("amp_gain_o", m_acc[REG_W], amp_gain_o);
         check_bit("led_armed_o", m_led, led_armed_o);
         check_bit("led_capture_o", m_state == TRIG_FIRED, led_capture_o);
      end
   end

   always @(posedge clk_usb) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Test failed");
         $fatal(1, "run did not finish within %0d cycles", CYCLE_LIMIT);
      end
   end

   initial begin
      logic [ADDR_W-1:0] a;
      reg_byte_t d, got;
      logic src;
      int n, ones;
      rng_drv = 32'hb1afd82b;
      rng_main = xorshift(32'hb1afd82b);
      reset = 1'b1;
      {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = '0;
      adc_valid_i = 1'b0;
      adc_data_i = '0;
      repeat (2) @(posedge clk_usb);
      reset <= 1'b0;
      repeat (40) @(posedge clk_usb);  // ramp source after reset
      repeat (24) begin
         rng_main = xorshift(rng_main);
         a = rng_main[2:0];
         d = rng_main[15:8];
         bus_write(a, d);
         bus_read(a, got);
         if (a != 3'd4) check_byte("wb_dat_o", written_value(a, d), got);
      end
      for (int r = 0; r < ROUNDS; r++) begin
         rng_main = xorshift(rng_main);
         src = (r % 4 != 3);
         bus_write(3'd1, rng_main[7:0]);
         bus_write(3'd2, {4'b0, rng_main[11:8]});
         bus_write(3'd3, {6'b0, src, 1'b0});
         bus_write(3'd3, {6'b0, src, 1'b1});  // arm edge
         n = 0;
         while (!trigger_adc_o && n < 150) begin
            @(negedge clk_usb);
            n++;
         end
         repeat (20) @(posedge clk_usb);  // no second pulse expected
         bus_read(3'd4, got);
      end
      repeat (4) begin
         rng_main = xorshift(rng_main);
         d = rng_main[23:16];
         bus_write(3'd0, d);
         repeat (3) @(posedge clk_usb);
         ones = 0;
         repeat (256) begin
            @(negedge clk_usb);
            ones += int'(amp_gain_o);
         end
         check_count("amp_gain_o high count", int'(d), ones);
      end
      $display("Test passed");
      $finish;
   end

endmodule

//--- flist.f
+incdir+.
adc_front_pkg.sv
adc_ctrl_if.sv
adc_reg_decode.sv
adc_level_trigger.sv
adc_gain_pwm.sv
adc_front_top.sv
tb_adc_front.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -f flist.f --top-module tb_adc_front -o sim_adc_front &&
./obj_dir/sim_adc_front | tee /dev/stderr | grep -q "Test passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
